/* Bender.yml */
package:
  name: coh_mesi

sources:
  - verilog/coh_pkg.sv
  - verilog/snoop_bus_if.sv
  - verilog/coh_cache.sv
  - verilog/bus_ctrl.sv
  - verilog/coh_top.sv
  - target: test
    files:
      - tb/tb_coh_top.sv

/* all.f */
verilog/coh_pkg.sv
verilog/snoop_bus_if.sv
verilog/coh_cache.sv
verilog/bus_ctrl.sv
verilog/coh_top.sv
tb/tb_coh_top.sv

/* tb/tb_coh_top.sv */
/*
 * Testbench for the MESI snooping subsystem
 * Two CPUs driven from a stimulus table, an L2 word memory with random
 * stall cycles, and a reference memory that gives the expected words
 */
`timescale 1ns/1ps
`default_nettype none

module tb_coh_top;
    import coh_pkg::*;

    localparam int NUM_CPUS = 2;
    localparam int N_FIXED  = 9;
    localparam int N_RAND   = 40;
    localparam int N_TESTS  = N_FIXED + N_RAND;
    localparam int L2_NONE     = 0;
    localparam int L2_NO_WRITE = 1;   // No L2 write may happen during the entry
    localparam int L2_BLOCK    = 2;   // L2 block at t_l2a must match the reference

    logic                clk;
    logic                rst_n;
    logic [NUM_CPUS-1:0] cpu_ren;
    logic [NUM_CPUS-1:0] cpu_wen;
    logic [ADDR_W-1:0]   cpu_addr  [NUM_CPUS];
    logic [WORD_W-1:0]   cpu_wdata [NUM_CPUS];
    logic [WORD_W-1:0]   cpu_rdata [NUM_CPUS];
    logic [NUM_CPUS-1:0] cpu_busy;
    logic                l2_ren;
    logic                l2_wen;
    logic [ADDR_W-1:0]   l2_addr;
    logic [WORD_W-1:0]   l2_store;
    logic [WORD_W-1:0]   l2_load;
    l2_state_e           l2_state;

    // Stimulus table
    string       t_name  [N_TESTS];
    int          t_cpu   [N_TESTS];
    bit          t_wr    [N_TESTS];
    logic [31:0] t_addr  [N_TESTS];
    logic [31:0] t_data  [N_TESTS];
    int          t_l2chk [N_TESTS];
    logic [31:0] t_l2a   [N_TESTS];
    int          n_entries = 0;

    logic [31:0] ref_mem [logic [31:0]];
    logic [31:0] l2_mem  [logic [31:0]];
    int unsigned l2_wr_count = 0;
    int          l2_wait = 0;
    integer      seed = 32'h78d;
    int          n_pass = 0;
    int          n_fail = 0;

    coh_top #(
        .NUM_CPUS (NUM_CPUS),
        .NUM_SETS (4)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_ren   (cpu_ren),
        .cpu_wen   (cpu_wen),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .cpu_busy  (cpu_busy),
        .l2_ren    (l2_ren),
        .l2_wen    (l2_wen),
        .l2_addr   (l2_addr),
        .l2_store  (l2_store),
        .l2_load   (l2_load),
        .l2_state  (l2_state)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Odd multiplier keeps every address bit in the pattern
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    task automatic add_entry(input string name, input int cpu, input bit wr,
                             input logic [31:0] addr, input logic [31:0] data,
                             input int l2chk, input logic [31:0] l2a);
        t_name[n_entries]  = name;
        t_cpu[n_entries]   = cpu;
        t_wr[n_entries]    = wr;
        t_addr[n_entries]  = addr;
        t_data[n_entries]  = data;
        t_l2chk[n_entries] = l2chk;
        t_l2a[n_entries]   = l2a;
        n_entries++;
    endtask

    task automatic build_table;
        logic [31:0] a;
        logic [31:0] d;
        bit          wr;
        add_entry("cold_rd",    0, 0, 32'h040, 0,            L2_NO_WRITE, 0);
        add_entry("c2c_wr0",    0, 1, 32'h088, 32'hC0DE_0002, L2_NONE,    0);
        add_entry("c2c_rd1",    1, 0, 32'h088, 0,            L2_BLOCK,    32'h088);
        add_entry("inv_rd0",    0, 0, 32'h150, 0,            L2_NONE,     0);
        add_entry("inv_rd1",    1, 0, 32'h150, 0,            L2_NONE,     0);
        add_entry("inv_wr1",    1, 1, 32'h150, 32'h3333_0003, L2_NONE,    0);
        add_entry("inv_rd0b",   0, 0, 32'h150, 0,            L2_NONE,     0);
        add_entry("evict_wr0",  0, 1, 32'h1D8, 32'h4444_0004, L2_NONE,    0);
        add_entry("evict_rd0",  0, 0, 32'h3D8, 0,            L2_BLOCK,    32'h1D8);
        // Tags 1..3 over sets 1 and 2, either word of the block
        for (int k = 0; k < N_RAND; k++) begin
            a  = 32'h1000 * (1 + $unsigned($random(seed)) % 3);
            a  = a + ((($unsigned($random(seed)) % 2) + 1) << 3);
            a  = a + 4 * ($unsigned($random(seed)) % 2);
            d  = $random(seed);
            wr = $random(seed);
            add_entry($sformatf("rnd_%0d", k), $unsigned($random(seed)) % 2, wr, a, d,
                      L2_NONE, 0);
        end
    endtask

    task automatic preload_memories;
        logic [31:0] a;
        for (int i = 0; i < N_TESTS; i++) begin
            for (int w = 0; w < BLOCK_WORDS; w++) begin
                a = (t_addr[i] & ~32'h7) + 4 * w;
                if (!ref_mem.exists(a))
                    ref_mem[a] = fill_word(a);
            end
        end
        foreach (ref_mem[k])
            l2_mem[k] = ref_mem[k];
    endtask

    task automatic serve_access;
        l2_state = L2_ACCESS;
        if (l2_wen) begin
            l2_mem[l2_addr] = l2_store;
            l2_wr_count++;
        end else begin
            l2_load = l2_mem.exists(l2_addr) ? l2_mem[l2_addr] : fill_word(l2_addr);
        end
    endtask

    // L2 model, 0 to 3 busy cycles ahead of each word
    always @(negedge clk) begin
        if (!rst_n) begin
            l2_state = L2_FREE;
        end else if (l2_state == L2_BUSY) begin
            l2_wait = l2_wait - 1;
            if (l2_wait == 0)
                serve_access();
        end else if (l2_ren || l2_wen) begin
            l2_wait = $unsigned($random(seed)) % 4;
            if (l2_wait == 0)
                serve_access();
            else
                l2_state = L2_BUSY;
        end else begin
            l2_state = L2_FREE;
        end
    end

    task automatic run_entry(input int i);
        int          c;
        int          w;
        int unsigned wr_before;
        logic [31:0] got;
        logic [31:0] exp;
        logic [31:0] a;
        bit          ok;
        c            = t_cpu[i];
        wr_before    = l2_wr_count;
        ok           = 1'b1;
        cpu_addr[c]  = t_addr[i];
        cpu_wdata[c] = t_data[i];
        cpu_ren[c]   = !t_wr[i];
        cpu_wen[c]   = t_wr[i];
        if (t_wr[i])
            ref_mem[t_addr[i]] = t_data[i];
        do begin
            @(negedge clk);
        end while (cpu_busy[c]);
        got        = cpu_rdata[c];
        cpu_ren[c] = 1'b0;
        cpu_wen[c] = 1'b0;
        if (!t_wr[i]) begin
            exp = ref_mem[t_addr[i]];
            assert (got === exp) else begin
                $display("CHECK FAILED %s expected %h actual %h", t_name[i], exp, got);
                ok = 1'b0;
            end
        end
        if (t_l2chk[i] == L2_NO_WRITE) begin
            assert (l2_wr_count == wr_before) else begin
                $display("CHECK FAILED %s expected 0 L2 writes actual %0d",
                         t_name[i], l2_wr_count - wr_before);
                ok = 1'b0;
            end
        end else if (t_l2chk[i] == L2_BLOCK) begin
            for (w = 0; w < BLOCK_WORDS; w++) begin
                a = (t_l2a[i] & ~32'h7) + 4 * w;
                assert (l2_mem[a] === ref_mem[a]) else begin
                    $display("CHECK FAILED %s expected %h actual %h at L2 %h",
                             t_name[i], ref_mem[a], l2_mem[a], a);
                    ok = 1'b0;
                end
            end
        end
        $display("%-10s cpu%0d %s %h : %s", t_name[i], c, t_wr[i] ? "wr" : "rd",
                 t_addr[i], ok ? "ok" : "FAILED");
        if (ok)
            n_pass++;
        else
            n_fail++;
        @(negedge clk);   // Let the ack cycle pass
    endtask

    initial begin
        rst_n     = 1'b0;
        cpu_ren   = '0;
        cpu_wen   = '0;
        cpu_addr  = '{default: '0};
        cpu_wdata = '{default: '0};
        l2_load   = '0;
        l2_state  = L2_FREE;
        build_table();
        preload_memories();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < N_TESTS; i++)
            run_entry(i);
        $display("Summary: %0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // Watchdog, 40 cycles per table entry after reset
    initial begin
        repeat (8 + N_TESTS * 40) @(posedge clk);
        $display("ERROR: run hung, tests did not finish within %0d cycles", N_TESTS * 40);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/bus_ctrl.sv */
/*
 * Snoop bus controller
 * Round-robin grant over the caches, snoop broadcast and
 * two-beat L2 sequencing for block reads and write-backs
 */
`timescale 1ns/1ps
`default_nettype none

module bus_ctrl #(
    parameter int NUM_CPUS = 2
) (
    input  logic                        clk,
    input  logic                        rst_n,
    snoop_bus_if.ctrl                   bus [NUM_CPUS],
    output logic                        l2_ren,
    output logic                        l2_wen,
    output logic [coh_pkg::ADDR_W-1:0]  l2_addr,
    output logic [coh_pkg::WORD_W-1:0]  l2_store,
    input  logic [coh_pkg::WORD_W-1:0]  l2_load,
    input  coh_pkg::l2_state_e          l2_state
);
    import coh_pkg::*;

    localparam int CPU_W = (NUM_CPUS > 1) ? $clog2(NUM_CPUS) : 1;

    typedef enum logic [2:0] {C_IDLE, C_SNOOP, C_RESP, C_L2, C_DONE} ctrl_state_e;

    ctrl_state_e        st;
    logic [CPU_W-1:0]   ptr;
    logic [CPU_W-1:0]   gnt;
    logic [CPU_W-1:0]   pick;
    logic               any_req;
    bus_op_e            op_q;
    logic [ADDR_W-1:0]  blk_addr;
    logic [BLOCK_W-1:0] blk_data;
    logic [WSEL_W-1:0]  beat;
    logic               l2_write;
    logic               shared_q;
    logic               snp_valid_q;
    logic [NUM_CPUS-1:0] done_q;

    // Per-cache views of the interface array
    logic [NUM_CPUS-1:0] req_v;
    logic [NUM_CPUS-1:0] hit_v;
    logic [NUM_CPUS-1:0] dirty_v;
    bus_op_e             op_v    [NUM_CPUS];
    logic [ADDR_W-1:0]   addr_v  [NUM_CPUS];
    logic [BLOCK_W-1:0]  wb_v    [NUM_CPUS];
    logic [BLOCK_W-1:0]  sdata_v [NUM_CPUS];
    logic [BLOCK_W-1:0]  dirty_data;

    for (genvar i = 0; i < NUM_CPUS; i++) begin : g_port
        assign req_v[i]   = bus[i].req;
        assign op_v[i]    = bus[i].op;
        assign addr_v[i]  = bus[i].addr;
        assign wb_v[i]    = bus[i].wb_data;
        assign hit_v[i]   = bus[i].snp_hit;
        assign dirty_v[i] = bus[i].snp_dirty;
        assign sdata_v[i] = bus[i].snp_data;

        assign bus[i].done        = done_q[i];
        assign bus[i].fill_data   = blk_data;
        assign bus[i].fill_shared = shared_q;
        assign bus[i].snp_valid   = snp_valid_q && (gnt != CPU_W'(i));  // Skip requester
        assign bus[i].snp_addr    = blk_addr;
        assign bus[i].snp_op      = op_q;
    end

    // Round-robin pick starting at ptr
    always_comb begin
        int idx;
        any_req = 1'b0;
        pick    = ptr;
        for (int k = 0; k < NUM_CPUS; k++) begin
            idx = (int'(ptr) + k) % NUM_CPUS;
            if (!any_req && req_v[idx]) begin
                any_req = 1'b1;
                pick    = CPU_W'(idx);
            end
        end
    end

    always_comb begin
        dirty_data = '0;
        for (int i = 0; i < NUM_CPUS; i++)
            if (dirty_v[i])
                dirty_data = sdata_v[i];
    end

    assign l2_ren   = (st == C_L2) && !l2_write;
    assign l2_wen   = (st == C_L2) && l2_write;
    assign l2_addr  = {blk_addr[ADDR_W-1:OFF_W], beat, {BYTE_OFF_W{1'b0}}};
    assign l2_store = blk_data[beat*WORD_W +: WORD_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st          <= C_IDLE;
            ptr         <= '0;
            gnt         <= '0;
            op_q        <= BUS_RD;
            blk_addr    <= '0;
            beat        <= '0;
            l2_write    <= 1'b0;
            shared_q    <= 1'b0;
            snp_valid_q <= 1'b0;
            done_q      <= '0;
        end else begin
            case (st)
                C_IDLE: begin
                    if (any_req) begin
                        gnt      <= pick;
                        op_q     <= op_v[pick];
                        blk_addr <= addr_v[pick];
                        beat     <= '0;
                        if (op_v[pick] == BUS_WB) begin
                            l2_write <= 1'b1;  // No snoop for write-backs
                            st       <= C_L2;
                        end else begin
                            snp_valid_q <= 1'b1;
                            st          <= C_SNOOP;
                        end
                    end
                end
                C_SNOOP: begin
                    snp_valid_q <= 1'b0;
                    st          <= C_RESP;
                end
                C_RESP: begin
                    shared_q <= (|hit_v) && (op_q == BUS_RD);
                    l2_write <= |dirty_v;  // Dirty block also goes to L2
                    st       <= C_L2;
                end
                C_L2: begin
                    if (l2_state == L2_ACCESS) begin
                        if (beat == WSEL_W'(BLOCK_WORDS - 1)) begin
                            done_q[gnt] <= 1'b1;
                            st          <= C_DONE;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                C_DONE: begin
                    done_q <= '0;
                    ptr    <= (int'(gnt) == NUM_CPUS - 1) ? '0 : gnt + 1'b1;
                    st     <= C_IDLE;
                end
                default: st <= C_IDLE;
            endcase
        end
    end

    // Block buffer, loaded from the victim, the dirty responder or L2
    always_ff @(posedge clk) begin
        if (st == C_IDLE && any_req && op_v[pick] == BUS_WB)
            blk_data <= wb_v[pick];
        else if (st == C_RESP && |dirty_v)
            blk_data <= dirty_data;
        else if (st == C_L2 && !l2_write && l2_state == L2_ACCESS)
            blk_data[beat*WORD_W +: WORD_W] <= l2_load;
    end

    // MESI allows only one owner of a dirty block
    a_one_dirty: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(dirty_v));

    a_l2_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(l2_ren && l2_wen));

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        |done_q |=> !(|done_q));

endmodule

`default_nettype wire

/* verilog/coh_cache.sv */
/*
 * Direct-mapped L1 data cache with MESI line states
 * Serves word reads and writes from one processor, issues
 * bus requests on misses and upgrades, and answers snoops
 */
`timescale 1ns/1ps
`default_nettype none

module coh_cache #(
    parameter int NUM_SETS = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ren,
    input  logic                        wen,
    input  logic [coh_pkg::ADDR_W-1:0]  addr,
    input  logic [coh_pkg::WORD_W-1:0]  wdata,
    output logic [coh_pkg::WORD_W-1:0]  rdata,
    output logic                        busy,
    snoop_bus_if.cache                  bus
);
    import coh_pkg::*;

    localparam int IDX_W = (NUM_SETS > 1) ? $clog2(NUM_SETS) : 1;
    localparam int TAG_W = ADDR_W - IDX_W - OFF_W;

    typedef enum logic [1:0] {IDLE, EVICT, FETCH, COMMIT} cache_state_e;

    // Line storage
    logic [TAG_W-1:0]   tag_q  [NUM_SETS];
    logic [BLOCK_W-1:0] data_q [NUM_SETS];
    mesi_state_e        line_q [NUM_SETS];

    cache_state_e       st;
    logic               ack;           // One-cycle processor completion
    logic               req_q;
    bus_op_e            op_q;
    logic [ADDR_W-1:0]  bus_addr_q;
    logic [BLOCK_W-1:0] wb_q;
    logic               snp_hit_q;
    logic               snp_dirty_q;
    logic [BLOCK_W-1:0] snp_data_q;

    logic [IDX_W-1:0]   req_idx;
    logic [TAG_W-1:0]   req_tag;
    logic [WSEL_W-1:0]  word_sel;
    logic [IDX_W-1:0]   snp_idx;
    logic [TAG_W-1:0]   snp_tag;
    logic               tag_hit;
    logic               snp_match;
    logic               accept;
    logic               hit_we;
    logic               evict_start;
    logic               fill_we;
    logic [BLOCK_W-1:0] merged;

    assign req_idx  = addr[OFF_W +: IDX_W];
    assign req_tag  = addr[ADDR_W-1 -: TAG_W];
    assign word_sel = addr[BYTE_OFF_W +: WSEL_W];
    assign snp_idx  = bus.snp_addr[OFF_W +: IDX_W];
    assign snp_tag  = bus.snp_addr[ADDR_W-1 -: TAG_W];

    assign tag_hit   = (line_q[req_idx] != INVALID) && (tag_q[req_idx] == req_tag);
    assign snp_match = (line_q[snp_idx] != INVALID) && (tag_q[snp_idx] == snp_tag);

    // Hold off a new access while a snoop lands on the same set
    assign accept = (st == IDLE) && !ack && (ren || wen) &&
                    !(bus.snp_valid && (snp_idx == req_idx));
    assign hit_we = accept && wen && tag_hit &&
                    (line_q[req_idx] == EXCLUSIVE || line_q[req_idx] == MODIFIED);
    assign evict_start = accept && !tag_hit && (line_q[req_idx] == MODIFIED);
    assign fill_we = (st == FETCH) && req_q && bus.done;

    always_comb begin
        merged = bus.fill_data;
        if (wen)
            merged[word_sel*WORD_W +: WORD_W] = wdata;  // Write merges into the fill
    end

    assign busy        = (ren || wen) && !ack;
    assign bus.req     = req_q;
    assign bus.op      = op_q;
    assign bus.addr    = bus_addr_q;
    assign bus.wb_data = wb_q;
    assign bus.snp_hit   = snp_hit_q;
    assign bus.snp_dirty = snp_dirty_q;
    assign bus.snp_data  = snp_data_q;

    // Control state, line states and snoop responder
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st          <= IDLE;
            ack         <= 1'b0;
            req_q       <= 1'b0;
            op_q        <= BUS_RD;
            bus_addr_q  <= '0;
            snp_hit_q   <= 1'b0;
            snp_dirty_q <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++)
                line_q[s] <= INVALID;
        end else begin
            ack         <= 1'b0;
            snp_hit_q   <= bus.snp_valid && snp_match;
            snp_dirty_q <= bus.snp_valid && snp_match && (line_q[snp_idx] == MODIFIED);

            // Snoop effect first, so a pending miss never keeps a stale line
            if (bus.snp_valid && snp_match) begin
                if (bus.snp_op == BUS_RDX)
                    line_q[snp_idx] <= INVALID;
                else if (line_q[snp_idx] == EXCLUSIVE || line_q[snp_idx] == MODIFIED)
                    line_q[snp_idx] <= SHARED;
            end

            case (st)
                IDLE: begin
                    if (accept) begin
                        if (tag_hit && ren) begin
                            ack <= 1'b1;
                        end else if (hit_we) begin
                            line_q[req_idx] <= MODIFIED;  // Silent E to M
                            ack             <= 1'b1;
                        end else if (evict_start) begin
                            req_q      <= 1'b1;
                            op_q       <= BUS_WB;
                            bus_addr_q <= {tag_q[req_idx], req_idx, {OFF_W{1'b0}}};
                            st         <= EVICT;
                        end else begin
                            st <= FETCH;  // Miss or upgrade from SHARED
                        end
                    end
                end
                EVICT: begin
                    if (bus.done) begin
                        req_q           <= 1'b0;
                        line_q[req_idx] <= INVALID;
                        st              <= FETCH;
                    end
                end
                FETCH: begin
                    if (!req_q) begin
                        req_q      <= 1'b1;
                        op_q       <= wen ? BUS_RDX : BUS_RD;
                        bus_addr_q <= {addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
                    end else if (bus.done) begin
                        req_q <= 1'b0;
                        if (wen)
                            line_q[req_idx] <= MODIFIED;
                        else
                            line_q[req_idx] <= bus.fill_shared ? SHARED : EXCLUSIVE;
                        st <= COMMIT;
                    end
                end
                COMMIT: begin
                    ack <= 1'b1;
                    st  <= IDLE;
                end
                default: st <= IDLE;
            endcase
        end
    end

    // Tags, data and payload registers
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_q[req_idx]  <= req_tag;
            data_q[req_idx] <= merged;
            rdata           <= merged[word_sel*WORD_W +: WORD_W];
        end else if (hit_we) begin
            data_q[req_idx][word_sel*WORD_W +: WORD_W] <= wdata;
        end else if (accept && ren && tag_hit) begin
            rdata <= data_q[req_idx][word_sel*WORD_W +: WORD_W];
        end
        if (evict_start)
            wb_q <= data_q[req_idx];
        if (bus.snp_valid)
            snp_data_q <= data_q[snp_idx];
    end

    a_one_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        !(ren && wen));

    // Request held steady across the whole bus transaction
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bus.req && !bus.done |=> bus.req && $stable(bus.op) && $stable(bus.addr));

endmodule

`default_nettype wire

/* verilog/coh_pkg.sv */
/*
 * Coherence package
 * Address and data widths, MESI line states, snoop bus opcodes
 * and L2 response states shared by the caches and the bus controller
 */
`default_nettype none

package coh_pkg;

    localparam int ADDR_W      = 32;
    localparam int WORD_W      = 32;
    localparam int BLOCK_WORDS = 2;
    localparam int BLOCK_W     = WORD_W * BLOCK_WORDS;

    // Byte address split
    localparam int BYTE_OFF_W  = $clog2(WORD_W / 8);   // Byte within a word
    localparam int WSEL_W      = $clog2(BLOCK_WORDS);  // Word within a block
    localparam int OFF_W       = WSEL_W + BYTE_OFF_W;  // Block offset

    typedef enum logic [1:0] {
        INVALID,
        SHARED,
        EXCLUSIVE,
        MODIFIED
    } mesi_state_e;

    typedef enum logic [1:0] {
        BUS_RD,     // Read miss
        BUS_RDX,    // Read for ownership or upgrade
        BUS_WB      // Dirty eviction
    } bus_op_e;

    // Same encoding as the L2 side uses
    typedef enum logic [1:0] {
        L2_FREE,
        L2_BUSY,
        L2_ACCESS
    } l2_state_e;

endpackage

`default_nettype wire

/* verilog/coh_top.sv */
/*
 * MESI snooping subsystem top
 * NUM_CPUS private L1 caches on one snoop bus, drained to L2
 */
`timescale 1ns/1ps
`default_nettype none

module coh_top #(
    parameter int NUM_CPUS = 2,
    parameter int NUM_SETS = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [NUM_CPUS-1:0]         cpu_ren,
    input  logic [NUM_CPUS-1:0]         cpu_wen,
    input  logic [coh_pkg::ADDR_W-1:0]  cpu_addr  [NUM_CPUS],
    input  logic [coh_pkg::WORD_W-1:0]  cpu_wdata [NUM_CPUS],
    output logic [coh_pkg::WORD_W-1:0]  cpu_rdata [NUM_CPUS],
    output logic [NUM_CPUS-1:0]         cpu_busy,
    output logic                        l2_ren,
    output logic                        l2_wen,
    output logic [coh_pkg::ADDR_W-1:0]  l2_addr,
    output logic [coh_pkg::WORD_W-1:0]  l2_store,
    input  logic [coh_pkg::WORD_W-1:0]  l2_load,
    input  coh_pkg::l2_state_e          l2_state
);

    snoop_bus_if sbus [NUM_CPUS] ();

    for (genvar i = 0; i < NUM_CPUS; i++) begin : g_cpu
        coh_cache #(
            .NUM_SETS (NUM_SETS)
        ) u_cache (
            .clk   (clk),
            .rst_n (rst_n),
            .ren   (cpu_ren[i]),
            .wen   (cpu_wen[i]),
            .addr  (cpu_addr[i]),
            .wdata (cpu_wdata[i]),
            .rdata (cpu_rdata[i]),
            .busy  (cpu_busy[i]),
            .bus   (sbus[i])
        );
    end

    bus_ctrl #(
        .NUM_CPUS (NUM_CPUS)
    ) u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (sbus),
        .l2_ren   (l2_ren),
        .l2_wen   (l2_wen),
        .l2_addr  (l2_addr),
        .l2_store (l2_store),
        .l2_load  (l2_load),
        .l2_state (l2_state)
    );

endmodule

`default_nettype wire

/* verilog/snoop_bus_if.sv */
/*
 * Snoop bus link between one L1 cache and the bus controller
 * Carries the cache's bus request, the fill completion,
 * the snoop broadcast and the cache's snoop response
 */
`timescale 1ns/1ps
`default_nettype none

interface snoop_bus_if;
    import coh_pkg::*;

    // Request from the cache, held until done
    logic                  req;
    bus_op_e               op;
    logic [ADDR_W-1:0]     addr;       // Block aligned
    logic [BLOCK_W-1:0]    wb_data;    // Victim block for BUS_WB

    // Completion from the controller
    logic                  done;
    logic [BLOCK_W-1:0]    fill_data;
    logic                  fill_shared;

    // Snoop broadcast to the other caches
    logic                  snp_valid;
    logic [ADDR_W-1:0]     snp_addr;
    bus_op_e               snp_op;

    // Registered snoop response, one cycle after snp_valid
    logic                  snp_hit;
    logic                  snp_dirty;
    logic [BLOCK_W-1:0]    snp_data;

    modport cache (
        output req, op, addr, wb_data,
        output snp_hit, snp_dirty, snp_data,
        input  done, fill_data, fill_shared,
        input  snp_valid, snp_addr, snp_op
    );

    modport ctrl (
        input  req, op, addr, wb_data,
        input  snp_hit, snp_dirty, snp_data,
        output done, fill_data, fill_shared,
        output snp_valid, snp_addr, snp_op
    );

endinterface

`default_nettype wire
